// File: build.f
+incdir+include
source/uop_pkg.sv
source/iq_pkg.sv
source/iq_write_if.sv
source/iq_dispatch.sv
source/iq_entry_array.sv
source/iq_age_matrix.sv
source/iq_issue.sv
source/issue_queue_top.sv
tb/tb_issue_queue.sv

// File: run.sh
#!/bin/sh
# compile the issue queue testbench with Verilator and run it
# exit status is nonzero when the build fails or the run ends in $fatal
verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module tb_issue_queue -o tb_issue_queue \
  && ./obj_dir/tb_issue_queue \
  || { echo "simulation did not pass"; exit 1; }

// File: tb/tb_issue_queue.sv
`timescale 1ns/1ps
`include "iq_defines.svh"

module tb_issue_queue;
  import uop_pkg::*;

  localparam int STIM_CYCLES = 2000;
  localparam int DRAIN_CYCLES = 200;
  // reset, stimulus and drain, plus margin
  localparam int MAX_CYCLES = 3000;
  // small tag pool so wakeups hit often
  localparam int POOL_SIZE = 8;
  localparam tag_t TAG_BASE = tag_t'(16);

  logic clk;
  logic rst;
  logic [`IQ_WRITE_PORTS-1:0] dispatch_valid;
  uop_t [`IQ_WRITE_PORTS-1:0] dispatch_uop;
  logic dispatch_ready;
  logic wakeup_valid;
  tag_t wakeup_tag;
  logic issue_valid;
  uop_t issue_uop;

  integer seed;
  int cycle_cnt = 0;
  string test_name;
  logic [7:0] next_id;

  // reference model, list order is age order
  uop_t model_q[$];
  logic exp_valid;
  uop_t exp_uop;

  issue_queue_top u_issue_queue_top (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_uop   (dispatch_uop),
    .dispatch_ready (dispatch_ready),
    .wakeup_valid   (wakeup_valid),
    .wakeup_tag     (wakeup_tag),
    .issue_valid    (issue_valid),
    .issue_uop      (issue_uop)
  );

  // 40 ns period
  always #20 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("ERROR: %s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("FAILED %s %s: expected %0h actual %0h", test_name, what, expected, actual);
    $display("Something failed");
    $fatal(1);
  endtask

  // runaway guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      report_failure("run exceeded the cycle limit without finishing");
    end
  end

  // broadcast rule, any source with a matching tag becomes ready
  function automatic uop_t apply_wakeup(input uop_t u, input logic wv, input tag_t wt);
    uop_t r;
    r = u;
    if (wv && (u.src1 == wt)) begin
      r.src1_ready = 1'b1;
    end
    if (wv && (u.src2 == wt)) begin
      r.src2_ready = 1'b1;
    end
    return r;
  endfunction

  task automatic pick_tag(output tag_t t);
    int r;
    r = $random(seed);
    t = TAG_BASE + tag_t'($unsigned(r) % POOL_SIZE);
  endtask

  // sequential id, random tags and readiness
  task automatic make_uop(output uop_t u);
    int r;
    tag_t t;
    u = '0;
    u.id = next_id;
    next_id = next_id + 8'd1;
    pick_tag(t);
    u.dest = t;
    pick_tag(t);
    u.src1 = t;
    pick_tag(t);
    u.src2 = t;
    r = $random(seed);
    u.src1_ready = r[0];
    u.src2_ready = r[1];
    u.op = r[7:2];
  endtask

  // called right after a rising edge
  task automatic drive_inputs(input bit drain, input int n);
    uop_t u;
    tag_t t;
    int r;
    if (drain) begin
      // no dispatch, sweep every pool tag
      dispatch_valid <= '0;
      wakeup_valid <= 1'b1;
      wakeup_tag <= TAG_BASE + tag_t'(n % POOL_SIZE);
    end else begin
      for (int p = 0; p < `IQ_WRITE_PORTS; p++) begin
        make_uop(u);
        dispatch_uop[p] <= u;
      end
      r = $random(seed);
      dispatch_valid <= `IQ_WRITE_PORTS'(r);
      wakeup_valid <= r[2];
      pick_tag(t);
      wakeup_tag <= t;
    end
  endtask

  // predict the coming edge from the inputs now applied
  task automatic step_model;
    int pick;
    logic accept;
    pick = -1;
    for (int i = 0; i < model_q.size(); i++) begin
      if (pick < 0 && model_q[i].src1_ready && model_q[i].src2_ready) begin
        pick = i;
      end
    end
    // free count before the edge decides acceptance
    accept = (`IQ_DEPTH - model_q.size()) >= `IQ_WRITE_PORTS;
    exp_valid = (pick >= 0);
    if (pick >= 0) begin
      exp_uop = model_q[pick];
      model_q.delete(pick);
    end
    for (int i = 0; i < model_q.size(); i++) begin
      model_q[i] = apply_wakeup(model_q[i], wakeup_valid, wakeup_tag);
    end
    // port 0 enters first, so it is older
    if (accept) begin
      for (int p = 0; p < `IQ_WRITE_PORTS; p++) begin
        if (dispatch_valid[p]) begin
          model_q.push_back(apply_wakeup(dispatch_uop[p], wakeup_valid, wakeup_tag));
        end
      end
    end
  endtask

  // sampled at the falling edge, outputs settled
  task automatic check_outputs;
    logic exp_ready;
    exp_ready = (`IQ_DEPTH - model_q.size()) >= `IQ_WRITE_PORTS;
    assert (dispatch_ready == exp_ready)
      else report_mismatch("dispatch_ready", 64'(exp_ready), 64'(dispatch_ready));
    // whatever the DUT issues must carry both sources ready
    if (issue_valid) begin
      assert (issue_uop.src1_ready && issue_uop.src2_ready)
        else report_failure("micro-op issued with a source not ready");
    end
    assert (issue_valid == exp_valid)
      else report_mismatch("issue_valid", 64'(exp_valid), 64'(issue_valid));
    if (exp_valid) begin
      assert (issue_uop == exp_uop)
        else report_mismatch("issue_uop", 64'(exp_uop), 64'(issue_uop));
    end
  endtask

  initial begin
    seed = 32'h8179e436;
    clk = 1'b0;
    rst = `RST;
    dispatch_valid = '0;
    dispatch_uop = '0;
    wakeup_valid = 1'b0;
    wakeup_tag = '0;
    next_id = 8'd0;
    exp_valid = 1'b0;
    exp_uop = '0;
    test_name = "reset";
    repeat (8) @(posedge clk);
    rst <= ~`RST;
    // empty queue, nothing issued, accepting
    @(negedge clk);
    check_outputs();
    step_model();
    test_name = "random";
    for (int n = 0; n < STIM_CYCLES; n++) begin
      @(posedge clk);
      drive_inputs(1'b0, n);
      @(negedge clk);
      check_outputs();
      step_model();
    end
    test_name = "drain";
    for (int n = 0; n < DRAIN_CYCLES; n++) begin
      @(posedge clk);
      drive_inputs(1'b1, n);
      @(negedge clk);
      check_outputs();
      step_model();
    end
    // one idle edge to settle the last prediction
    @(posedge clk);
    wakeup_valid <= 1'b0;
    @(negedge clk);
    check_outputs();
    assert (model_q.size() == 0)
      else report_failure("micro-ops still queued after the drain");
    assert (!issue_valid)
      else report_failure("issue still valid after the drain");
    $display("Everything OK");
    $finish;
  end

endmodule

// File: source/issue_queue_top.sv
`timescale 1ns/1ps
`include "iq_defines.svh"

module issue_queue_top (
  input  logic                                    clk,
  input  logic                                    rst,
  // dispatch side
  input  logic [`IQ_WRITE_PORTS-1:0]              dispatch_valid,
  input  uop_pkg::uop_t [`IQ_WRITE_PORTS-1:0]     dispatch_uop,
  output logic                                    dispatch_ready,
  // result tag broadcast
  input  logic                                    wakeup_valid,
  input  uop_pkg::tag_t                           wakeup_tag,
  // issue side
  output logic                                    issue_valid,
  output uop_pkg::uop_t                           issue_uop
);
  import uop_pkg::*;
  import iq_pkg::*;

  // entries ready to go
  slot_vec_t ready;
  // oldest ready, one-hot or zero
  slot_vec_t select;
  // stored micro-ops
  uop_t [`IQ_DEPTH-1:0] payload;

  // dispatch to storage and age tracking
  iq_write_if wr_if ();

  iq_dispatch u_iq_dispatch (
    .dispatch_valid (dispatch_valid),
    .dispatch_uop   (dispatch_uop),
    .dispatch_ready (dispatch_ready),
    .wr             (wr_if.dispatch)
  );

  iq_entry_array u_iq_entry_array (
    .clk          (clk),
    .rst          (rst),
    .wr           (wr_if.entry),
    .wakeup_valid (wakeup_valid),
    .wakeup_tag   (wakeup_tag),
    .select       (select),
    .ready        (ready),
    .payload      (payload)
  );

  iq_age_matrix u_iq_age_matrix (
    .clk    (clk),
    .rst    (rst),
    .wr     (wr_if.age),
    .ready  (ready),
    .select (select)
  );

  iq_issue u_iq_issue (
    .clk         (clk),
    .rst         (rst),
    .select      (select),
    .payload     (payload),
    .issue_valid (issue_valid),
    .issue_uop   (issue_uop)
  );

endmodule

// File: source/iq_issue.sv
`timescale 1ns/1ps
`include "iq_defines.svh"

module iq_issue (
  input  logic                            clk,
  input  logic                            rst,
  input  iq_pkg::slot_vec_t               select,
  input  uop_pkg::uop_t [`IQ_DEPTH-1:0]   payload,
  output logic                            issue_valid,
  output uop_pkg::uop_t                   issue_uop
);
  import uop_pkg::*;

  // selected micro-op before the register
  uop_t mux_uop;

  // AND-OR mux, select is one-hot or zero
  always_comb begin
    mux_uop = '0;
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      mux_uop = uop_t'(mux_uop | (payload[i] & {$bits(uop_t){select[i]}}));
    end
  end

  // issue strobe level
  always_ff @(posedge clk or negedge rst) begin
    if (rst == `RST) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= |select;
    end
  end

  // issued payload, meaningful with issue_valid
  always_ff @(posedge clk) begin
    issue_uop <= mux_uop;
  end

endmodule

// File: source/iq_age_matrix.sv
`timescale 1ns/1ps
`include "iq_defines.svh"

module iq_age_matrix (
  input  logic               clk,
  input  logic               rst,
  iq_write_if.age            wr,
  input  iq_pkg::slot_vec_t  ready,
  output iq_pkg::slot_vec_t  select
);
  import iq_pkg::*;

  // age rows, row i lists entries older than i
  age_row_t [`IQ_DEPTH-1:0] age_q;
  age_row_t [`IQ_DEPTH-1:0] age_d;

  // enabled slot per port
  slot_vec_t [`IQ_WRITE_PORTS-1:0] wr_slot;
  // slots written by higher ports this cycle
  slot_vec_t [`IQ_WRITE_PORTS-1:0] younger;
  // all slots written this cycle
  slot_vec_t wr_any;

  always_comb begin
    wr_any = '0;
    for (int p = 0; p < `IQ_WRITE_PORTS; p++) begin
      wr_slot[p] = wr.slot[p] & {`IQ_DEPTH{wr.en[p]}};
      wr_any = wr_any | wr_slot[p];
    end
    // union of all higher ports, empty for the top port
    for (int p = 0; p < `IQ_WRITE_PORTS; p++) begin
      younger[p] = '0;
      for (int q = p + 1; q < `IQ_WRITE_PORTS; q++) begin
        younger[p] = younger[p] | wr_slot[q];
      end
    end
  end

  // next matrix
  always_comb begin
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      for (int j = 0; j < `IQ_DEPTH; j++) begin
        // new row all ones, new column cleared elsewhere
        age_d[i][j] = (age_q[i][j] & ~wr_any[j]) | wr_any[i];
        // lower port written now is older than higher port
        // so a higher port slot is never older for it
        for (int p = 0; p < `IQ_WRITE_PORTS; p++) begin
          if (wr_slot[p][i] && younger[p][j]) begin
            age_d[i][j] = 1'b0;
          end
        end
      end
    end
  end

  // only touched on dispatch
  always_ff @(posedge clk or negedge rst) begin
    if (rst == `RST) begin
      age_q <= '0;
    end else if (|wr.en) begin
      age_q <= age_d;
    end
  end

  // oldest ready wins
  always_comb begin
    age_row_t older_ready;
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      older_ready = age_q[i] & ready;
      // diagonal is meaningless
      older_ready[i] = 1'b0;
      select[i] = ready[i] & ~(|older_ready);
    end
  end

endmodule

// File: source/iq_entry_array.sv
`timescale 1ns/1ps
`include "iq_defines.svh"

module iq_entry_array (
  input  logic                                clk,
  input  logic                                rst,
  iq_write_if.entry                           wr,
  input  logic                                wakeup_valid,
  input  uop_pkg::tag_t                       wakeup_tag,
  input  iq_pkg::slot_vec_t                   select,
  output iq_pkg::slot_vec_t                   ready,
  output uop_pkg::uop_t [`IQ_DEPTH-1:0]       payload
);
  import uop_pkg::*;
  import iq_pkg::*;

  // control state
  slot_vec_t valid;
  slot_vec_t valid_d;
  // write mask over all ports
  slot_vec_t wr_mask;

  // stored micro-ops
  uop_t [`IQ_DEPTH-1:0] entries;
  uop_t [`IQ_DEPTH-1:0] entries_d;

  // apply a wakeup broadcast to one micro-op
  function automatic uop_t wake(input uop_t u, input logic hit_en, input tag_t tag);
    uop_t w;
    w = u;
    // compare against both sources
    if (hit_en && (u.src1 == tag)) begin
      w.src1_ready = 1'b1;
    end
    if (hit_en && (u.src2 == tag)) begin
      w.src2_ready = 1'b1;
    end
    return w;
  endfunction

  // union of enabled write slots
  always_comb begin
    wr_mask = '0;
    for (int p = 0; p < `IQ_WRITE_PORTS; p++) begin
      wr_mask = wr_mask | (wr.slot[p] & {`IQ_DEPTH{wr.en[p]}});
    end
  end

  // selected entry leaves, new writes arrive
  assign valid_d = (valid & ~select) | wr_mask;

  // next payload per entry
  always_comb begin
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      // held entries see the broadcast
      if (valid[i]) begin
        entries_d[i] = wake(entries[i], wakeup_valid, wakeup_tag);
      end else begin
        entries_d[i] = entries[i];
      end
      // incoming uop, same-edge wakeup merged
      for (int p = 0; p < `IQ_WRITE_PORTS; p++) begin
        if (wr.en[p] && wr.slot[p][i]) begin
          entries_d[i] = wake(wr.uop[p], wakeup_valid, wakeup_tag);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (rst == `RST) begin
      valid <= '0;
    end else begin
      valid <= valid_d;
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    entries <= entries_d;
  end

  assign wr.free = ~valid;

  // valid and both operands available
  always_comb begin
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      ready[i] = valid[i] & entries[i].src1_ready & entries[i].src2_ready;
    end
  end

  assign payload = entries;

endmodule

// File: source/iq_dispatch.sv
`timescale 1ns/1ps
`include "iq_defines.svh"

module iq_dispatch (
  input  logic [`IQ_WRITE_PORTS-1:0]                dispatch_valid,
  input  uop_pkg::uop_t [`IQ_WRITE_PORTS-1:0]       dispatch_uop,
  output logic                                      dispatch_ready,
  iq_write_if.dispatch                              wr
);
  import iq_pkg::*;

  // wide enough to count every entry free
  localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

  logic [CNT_W-1:0] free_cnt;
  slot_vec_t [`IQ_WRITE_PORTS-1:0] pick;

  // population count of the free vector
  always_comb begin
    free_cnt = '0;
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      free_cnt = free_cnt + CNT_W'(wr.free[i]);
    end
  end

  // accept only when every port could be served
  assign dispatch_ready = (free_cnt >= CNT_W'(`IQ_WRITE_PORTS));

  // priority search, port 0 takes lowest free slot
  // each later port takes the next one up
  always_comb begin
    slot_vec_t remaining;
    remaining = wr.free;
    for (int p = 0; p < `IQ_WRITE_PORTS; p++) begin
      // isolate lowest set bit
      pick[p] = remaining & (~remaining + 1'b1);
      // hide it from higher ports
      remaining = remaining & ~pick[p];
    end
  end

  // slots already one-hot, no decode downstream
  assign wr.slot = pick;

  // strobe per port, gated by the accept level
  assign wr.en = dispatch_valid & {`IQ_WRITE_PORTS{dispatch_ready}};

  // payload passes as is
  assign wr.uop = dispatch_uop;

endmodule

// File: source/iq_write_if.sv
`timescale 1ns/1ps
`include "iq_defines.svh"

interface iq_write_if;
  import uop_pkg::*;
  import iq_pkg::*;

  // per dispatch port write strobe
  logic [`IQ_WRITE_PORTS-1:0] en;
  // target entry per port, one-hot
  slot_vec_t [`IQ_WRITE_PORTS-1:0] slot;
  // micro-op per port
  uop_t [`IQ_WRITE_PORTS-1:0] uop;
  // free entries, registered state
  slot_vec_t free;

  modport dispatch (output en, output slot, output uop, input free);
  modport entry (input en, input slot, input uop, output free);
  modport age (input en, input slot);

endinterface

// File: source/iq_pkg.sv
`include "iq_defines.svh"

package iq_pkg;

  // one bit per queue entry
  // valid, ready, free, slot one-hot, select
  typedef logic [`IQ_DEPTH-1:0] slot_vec_t;

  // one age matrix row
  // bit j set in row i -> entry j older than entry i
  typedef logic [`IQ_DEPTH-1:0] age_row_t;

endpackage

// File: source/uop_pkg.sv
`include "iq_defines.svh"

package uop_pkg;

  // physical register tag
  typedef logic [`TAG_WIDTH-1:0] tag_t;

  // micro-op as held in the queue, 34 bits
  typedef struct packed {
    // sequence number, only for checking
    logic [7:0] id;
    tag_t       dest;
    tag_t       src1;
    tag_t       src2;
    // source operand availability
    logic       src1_ready;
    logic       src2_ready;
    logic [5:0] op;
  } uop_t;

endpackage

// File: include/iq_defines.svh
`ifndef IQ_DEFINES_SVH
`define IQ_DEFINES_SVH

// number of issue queue entries
`define IQ_DEPTH 8

// dispatch ports written per cycle
`define IQ_WRITE_PORTS 2

// physical register tag width
`define TAG_WIDTH 6

// active reset level, low
`define RST 1'b0

`endif
